// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module cache_tb -f sources.f

# the simulator exits nonzero on failure, keep its output for the search
output=$(./obj_dir/Vcache_tb 2>&1 || true)
echo "$output"

if grep -q "All tests passed" <<< "$output"; then
    exit 0
fi
exit 1

// ==== sources.f ====
verilog/cache_pkg.sv
verilog/cache_core.sv
verilog/cache_replace.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
tb/mem_model.sv
tb/cache_tb.sv

// ==== tb/cache_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_tb;

    localparam int WAYS           = 2;
    localparam int SETS           = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int IDX_W  = $clog2(SETS);
    localparam int WSEL_W = $clog2(WORDS_PER_LINE);
    localparam int OFF_W  = WSEL_W + 2;
    localparam int TAG_W  = 32 - IDX_W - OFF_W;
    localparam int LINE_W = WORDS_PER_LINE * 32;
    localparam int SWEEP_LEN    = 200;
    // directed accesses plus the sweep
    localparam int NUM_ACCESSES = 20 + SWEEP_LEN;

    logic              clk = 1'b0;
    logic              rst;
    logic              flush;
    logic              cpu_req;
    logic              cpu_we;
    cache_pkg::addr_t  cpu_addr;
    cache_pkg::word_t  cpu_wdata;
    logic              cpu_ack;
    cache_pkg::word_t  cpu_rdata;
    logic              mem_req;
    logic              mem_we;
    cache_pkg::addr_t  mem_addr;
    logic [LINE_W-1:0] mem_wdata;
    logic              mem_ack;
    logic [LINE_W-1:0] mem_rdata;
    logic [31:0]       read_count;
    logic [31:0]       write_count;

    // ========================================
    // reference model of memory and cache
    // ========================================
    cache_pkg::word_t ref_mem [cache_pkg::addr_t];
    logic [TAG_W-1:0] m_tag   [SETS][WAYS];
    logic             m_valid [SETS][WAYS];
    logic             m_dirty [SETS][WAYS];
    cache_pkg::word_t m_data  [SETS][WAYS][WORDS_PER_LINE];
    // fifo fill pointer per set
    int               m_ptr   [SETS];
    integer           seed = 32'h5fa4;

    always #20 clk = ~clk;

    cache_top #(.WAYS(WAYS), .SETS(SETS), .WORDS_PER_LINE(WORDS_PER_LINE)) DUT (
        .clk(clk), .rst(rst), .flush(flush),
        .cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
        .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    mem_model #(.WORDS_PER_LINE(WORDS_PER_LINE)) memory (
        .clk(clk), .rst(rst),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .read_count(read_count), .write_count(write_count)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] observed,
                               input logic [31:0] expected);
        if (observed !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, observed, expected);
            stop_with_failure("a checked value did not match");
        end
    endtask

    // byte address of one word built from tag, set, word and byte bits
    function automatic cache_pkg::addr_t word_addr(input logic [TAG_W-1:0] tag,
                                                   input int set, input int w);
        return {tag, IDX_W'(set), WSEL_W'(w), 2'b00};
    endfunction

    function automatic cache_pkg::word_t mem_word(input cache_pkg::addr_t a);
        if (ref_mem.exists(a))
            return ref_mem[a];
        return a ^ 32'hc0de0000;
    endfunction

    // flush drops lines and leaves the pointers alone
    task automatic clear_lines();
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
    endtask

    // ========================================
    // one processor access, predicted and checked
    // ========================================
    task automatic access(input logic we, input cache_pkg::addr_t addr,
                          input cache_pkg::word_t wdata);
        logic [TAG_W-1:0] tag;
        int               set;
        int               wsel;
        int               way;
        int               cycles;
        logic             hit;
        logic [31:0]      exp_reads;
        logic [31:0]      exp_writes;
        cache_pkg::word_t expected;
        tag  = addr[31 -: TAG_W];
        set  = int'(addr[OFF_W +: IDX_W]);
        wsel = int'(addr[2 +: WSEL_W]);
        hit  = 1'b0;
        way  = 0;
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        exp_reads  = read_count;
        exp_writes = write_count;
        if (!hit) begin
            way = m_ptr[set];
            // dirty victim goes back to memory first
            if (m_valid[set][way] && m_dirty[set][way]) begin
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    ref_mem[word_addr(m_tag[set][way], set, w)] = m_data[set][way][w];
                end
                exp_writes = exp_writes + 1;
            end
            // write-allocate refill
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                m_data[set][way][w] = mem_word(word_addr(tag, set, w));
            end
            exp_reads          = exp_reads + 1;
            m_tag[set][way]    = tag;
            m_valid[set][way]  = 1'b1;
            m_dirty[set][way]  = 1'b0;
            m_ptr[set]         = (m_ptr[set] + 1) % WAYS;
        end
        if (we) begin
            m_data[set][way][wsel] = wdata;
            m_dirty[set][way]      = 1'b1;
        end
        expected = m_data[set][way][wsel];
        // four-phase request
        cpu_req   = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        @(posedge clk);
        #1;
        cycles = 0;
        while (!cpu_ack) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        cpu_req = 1'b0;
        check_value("cpu_rdata", cpu_rdata, expected);
        check_value("read_count", read_count, exp_reads);
        check_value("write_count", write_count, exp_writes);
        if (hit)
            check_value("hit ack latency", cycles, 32'd2);
        // ack must fall before the next request
        while (cpu_ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic cpu_read(input cache_pkg::addr_t addr);
        access(1'b0, addr, '0);
    endtask

    task automatic cpu_write(input cache_pkg::addr_t addr, input cache_pkg::word_t data);
        access(1'b1, addr, data);
    endtask

    task automatic do_flush();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        clear_lines();
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic cold_read_then_hit();
        cache_pkg::addr_t a;
        a = word_addr(TAG_W'(5), 1, 2);
        cpu_read(a);
        check_value("cold read data", cpu_rdata, a ^ 32'hc0de0000);
        cpu_read(a);
        // other word of the same line
        cpu_read(word_addr(TAG_W'(5), 1, 0));
    endtask

    task automatic write_hit_and_allocate();
        cpu_write(word_addr(TAG_W'(5), 1, 3), 32'h1234_5678);
        cpu_read(word_addr(TAG_W'(5), 1, 3));
        cpu_write(word_addr(TAG_W'(7), 2, 0), 32'h0bad_f00d);
        cpu_read(word_addr(TAG_W'(7), 2, 0));
    endtask

    task automatic dirty_eviction();
        logic [31:0] wr0;
        cpu_write(word_addr(TAG_W'(1), 3, 0), 32'h1111_0001);
        cpu_read(word_addr(TAG_W'(2), 3, 1));
        wr0 = write_count;
        // set is full and its oldest way is the dirty one
        cpu_read(word_addr(TAG_W'(3), 3, 2));
        check_value("write-backs on dirty eviction", write_count - wr0, 32'd1);
        cpu_read(word_addr(TAG_W'(1), 3, 0));
        check_value("evicted word read back", cpu_rdata, 32'h1111_0001);
    endtask

    task automatic clean_eviction();
        logic [31:0] wr0;
        cpu_read(word_addr(TAG_W'(1), 0, 0));
        cpu_read(word_addr(TAG_W'(2), 0, 0));
        wr0 = write_count;
        cpu_read(word_addr(TAG_W'(3), 0, 0));
        cpu_read(word_addr(TAG_W'(1), 0, 0));
        check_value("write-backs on clean eviction", write_count - wr0, 32'd0);
    endtask

    task automatic flush_discards_dirty();
        cache_pkg::addr_t a;
        logic [31:0]      rd0;
        a = word_addr(TAG_W'(5), 1, 1);
        cpu_write(a, 32'hdead_beef);
        do_flush();
        rd0 = read_count;
        cpu_read(a);
        check_value("reads after flush", read_count - rd0, 32'd1);
        check_value("data after flush", cpu_rdata, a ^ 32'hc0de0000);
    endtask

    // mixed reads and writes over 3 sets and 6 tags
    task automatic random_sweep();
        int               set;
        int               tag;
        int               w;
        logic             we;
        cache_pkg::word_t data;
        for (int i = 0; i < SWEEP_LEN; i++) begin
            set  = $unsigned($random(seed)) % 3;
            tag  = 8 + $unsigned($random(seed)) % 6;
            w    = $unsigned($random(seed)) % WORDS_PER_LINE;
            we   = $random(seed) % 2 != 0;
            data = $random(seed);
            access(we, word_addr(TAG_W'(tag), set, w), data);
        end
    endtask

    // watchdog sized from the worst miss per access
    initial begin
        #(NUM_ACCESSES * (4 * 4 + 8) * 40 + 4000);
        stop_with_failure("simulation timed out, the cache stopped answering");
    end

    initial begin
        rst       = 1'b1;
        flush     = 1'b0;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        clear_lines();
        for (int s = 0; s < SETS; s++) begin
            m_ptr[s] = 0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        cold_read_then_hit();
        write_hit_and_allocate();
        dirty_eviction();
        clean_eviction();
        flush_discards_dirty();
        random_sweep();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_model #(
    parameter int WORDS_PER_LINE = 4,
    localparam int LINE_W = WORDS_PER_LINE * 32
) (
    input  logic              clk,
    input  logic              rst,
    // line wide four-phase slave
    input  logic              mem_req,
    input  logic              mem_we,
    input  cache_pkg::addr_t  mem_addr,
    input  logic [LINE_W-1:0] mem_wdata,
    output logic              mem_ack,
    output logic [LINE_W-1:0] mem_rdata,
    // transfer counters
    output logic [31:0]       read_count,
    output logic [31:0]       write_count
);

    // only words that were written back
    cache_pkg::word_t store [cache_pkg::addr_t];
    integer seed = 32'h5fa4;
    int     r;
    int     delay;
    logic   busy;

    // unwritten words read as their address xor a marker
    function automatic cache_pkg::word_t read_word(input cache_pkg::addr_t a);
        if (store.exists(a))
            return store[a];
        return a ^ 32'hc0de0000;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_ack     <= 1'b0;
            mem_rdata   <= '0;
            busy        <= 1'b0;
            delay       <= 0;
            read_count  <= '0;
            write_count <= '0;
        end else if (mem_ack) begin
            // hold ack until req falls
            if (!mem_req)
                mem_ack <= 1'b0;
        end else if (mem_req && !busy) begin
            // random wait of 1 to 4 cycles
            r = $random(seed);
            busy  <= 1'b1;
            delay <= 1 + int'(r[1:0]);
        end else if (busy) begin
            if (delay > 1) begin
                delay <= delay - 1;
            end else begin
                busy    <= 1'b0;
                mem_ack <= 1'b1;
                if (mem_we) begin
                    for (int w = 0; w < WORDS_PER_LINE; w++) begin
                        store[mem_addr + cache_pkg::addr_t'(4 * w)] = mem_wdata[w*32 +: 32];
                    end
                    write_count <= write_count + 1;
                end else begin
                    // word 0 in the low bits
                    for (int w = 0; w < WORDS_PER_LINE; w++) begin
                        mem_rdata[w*32 +: 32] <= read_word(mem_addr + cache_pkg::addr_t'(4 * w));
                    end
                    read_count <= read_count + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cache_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_core #(
    parameter int WAYS           = 2,
    parameter int SETS           = 4,
    parameter int WORDS_PER_LINE = 4,
    localparam int WAY_W  = $clog2(WAYS),
    localparam int IDX_W  = $clog2(SETS),
    localparam int WSEL_W = $clog2(WORDS_PER_LINE),
    localparam int OFF_W  = WSEL_W + cache_pkg::BYTE_BITS,
    localparam int TAG_W  = 32 - IDX_W - OFF_W,
    localparam int LINE_W = WORDS_PER_LINE * cache_pkg::WORD_BITS
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    // lookup port that also addresses the store
    input  cache_pkg::addr_t  lookup_addr,
    output logic              lookup_hit,
    output logic [WAY_W-1:0]  lookup_way,
    output cache_pkg::word_t  lookup_data,
    // single word store
    input  logic              store_en,
    input  logic [WAY_W-1:0]  store_way,
    input  cache_pkg::word_t  store_data,
    // whole line refill
    input  logic              refill_en,
    input  cache_pkg::addr_t  refill_addr,
    input  logic [WAY_W-1:0]  refill_way,
    input  logic [LINE_W-1:0] refill_line,
    // victim read
    input  cache_pkg::addr_t  victim_addr,
    input  logic [WAY_W-1:0]  victim_way,
    output logic [TAG_W-1:0]  victim_tag,
    output logic              victim_dirty,
    output logic [LINE_W-1:0] victim_line
);

    // ========================================
    // storage
    // ========================================
    logic [TAG_W-1:0] tag_array   [SETS][WAYS];
    logic             valid_array [SETS][WAYS];
    logic             dirty_array [SETS][WAYS];
    cache_pkg::word_t data_array  [SETS][WAYS][WORDS_PER_LINE];

    logic [TAG_W-1:0]  lk_tag;
    logic [IDX_W-1:0]  lk_idx;
    logic [WSEL_W-1:0] lk_word;
    logic [TAG_W-1:0]  rf_tag;
    logic [IDX_W-1:0]  rf_idx;
    logic [IDX_W-1:0]  vc_idx;

    // address split from the top as tag then index then word then byte
    assign lk_tag  = lookup_addr[31 -: TAG_W];
    assign lk_idx  = lookup_addr[OFF_W +: IDX_W];
    assign lk_word = lookup_addr[cache_pkg::BYTE_BITS +: WSEL_W];
    assign rf_tag  = refill_addr[31 -: TAG_W];
    assign rf_idx  = refill_addr[OFF_W +: IDX_W];
    assign vc_idx  = victim_addr[OFF_W +: IDX_W];

    // ========================================
    // tag, valid and dirty
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    valid_array[s][w] <= 1'b0;
                    dirty_array[s][w] <= 1'b0;
                    tag_array[s][w]   <= '0;
                end
            end
        end else if (flush) begin
            // dirty data is dropped without write-back
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    valid_array[s][w] <= 1'b0;
                    dirty_array[s][w] <= 1'b0;
                    tag_array[s][w]   <= '0;
                end
            end
        end else begin
            // fresh line from memory is clean
            if (refill_en) begin
                tag_array[rf_idx][refill_way]   <= rf_tag;
                valid_array[rf_idx][refill_way] <= 1'b1;
                dirty_array[rf_idx][refill_way] <= 1'b0;
            end
            // line already valid here
            if (store_en) begin
                dirty_array[lk_idx][store_way] <= 1'b1;
            end
        end
    end

    // data words
    always_ff @(posedge clk) begin
        if (refill_en) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                data_array[rf_idx][refill_way][w] <=
                    refill_line[w*cache_pkg::WORD_BITS +: cache_pkg::WORD_BITS];
            end
        end
        if (store_en) begin
            data_array[lk_idx][store_way][lk_word] <= store_data;
        end
    end

    // ========================================
    // lookup and victim read
    // ========================================
    always_comb begin
        lookup_hit = 1'b0;
        lookup_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_array[lk_idx][w] && tag_array[lk_idx][w] == lk_tag) begin
                lookup_hit = 1'b1;
                lookup_way = WAY_W'(w);
            end
        end
    end

    // meaningful only with lookup_hit
    assign lookup_data = data_array[lk_idx][lookup_way][lk_word];

    assign victim_tag   = tag_array[vc_idx][victim_way];
    assign victim_dirty = dirty_array[vc_idx][victim_way];

    // word 0 in the low bits
    always_comb begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            victim_line[w*cache_pkg::WORD_BITS +: cache_pkg::WORD_BITS] =
                data_array[vc_idx][victim_way][w];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl #(
    parameter int WAYS           = 2,
    parameter int SETS           = 4,
    parameter int WORDS_PER_LINE = 4,
    localparam int WAY_W  = $clog2(WAYS),
    localparam int IDX_W  = $clog2(SETS),
    localparam int OFF_W  = $clog2(WORDS_PER_LINE) + cache_pkg::BYTE_BITS,
    localparam int TAG_W  = 32 - IDX_W - OFF_W,
    localparam int LINE_W = WORDS_PER_LINE * cache_pkg::WORD_BITS
) (
    input  logic              clk,
    input  logic              rst,
    // processor side as four-phase slave
    input  logic              cpu_req,
    input  logic              cpu_we,
    input  cache_pkg::addr_t  cpu_addr,
    input  cache_pkg::word_t  cpu_wdata,
    output logic              cpu_ack,
    output cache_pkg::word_t  cpu_rdata,
    // memory side as four-phase master
    output logic              mem_req,
    output logic              mem_we,
    output cache_pkg::addr_t  mem_addr,
    output logic [LINE_W-1:0] mem_wdata,
    input  logic              mem_ack,
    input  logic [LINE_W-1:0] mem_rdata,
    // to the core
    output cache_pkg::addr_t  lookup_addr,
    output logic              store_en,
    output logic [WAY_W-1:0]  store_way,
    output cache_pkg::word_t  store_data,
    output logic              refill_en,
    output cache_pkg::addr_t  refill_addr,
    output logic [WAY_W-1:0]  refill_way,
    output logic [LINE_W-1:0] refill_line,
    output cache_pkg::addr_t  victim_addr,
    output logic [WAY_W-1:0]  victim_way,
    // from the core
    input  logic              lookup_hit,
    input  logic [WAY_W-1:0]  lookup_way,
    input  cache_pkg::word_t  lookup_data,
    input  logic [TAG_W-1:0]  victim_tag,
    input  logic              victim_dirty,
    input  logic [LINE_W-1:0] victim_line,
    // replacement
    output logic [IDX_W-1:0]  index,
    output logic              advance,
    input  logic [WAY_W-1:0]  repl_way
);

    cache_pkg::ctrl_state_t state;

    // latched request
    cache_pkg::addr_t req_addr;
    logic             req_we;
    cache_pkg::word_t req_wdata;
    // victim way held over the miss
    logic [WAY_W-1:0] way_q;

    cache_pkg::addr_t fill_addr;
    cache_pkg::addr_t wb_addr;

    assign index     = req_addr[OFF_W +: IDX_W];
    assign fill_addr = {req_addr[31:OFF_W], OFF_W'(0)};
    // evicted line goes back under its own tag
    assign wb_addr   = {victim_tag, index, OFF_W'(0)};

    // ========================================
    // core and replacement hookup
    // ========================================
    assign lookup_addr = req_addr;
    assign victim_addr = req_addr;
    assign refill_addr = req_addr;
    // live pointer while deciding and the latched copy afterwards
    assign victim_way  = (state == cache_pkg::st_lookup) ? repl_way : way_q;
    assign refill_way  = way_q;
    assign refill_line = mem_rdata;
    // line written on the ack edge
    assign refill_en   = (state == cache_pkg::st_refill) && mem_req && mem_ack;
    assign advance     = refill_en;
    assign store_en    = (state == cache_pkg::st_store);
    assign store_way   = lookup_way;
    assign store_data  = req_wdata;

    // ========================================
    // state and handshake flags
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= cache_pkg::st_idle;
            cpu_ack <= 1'b0;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            case (state)
                cache_pkg::st_idle: begin
                    if (cpu_req)
                        state <= cache_pkg::st_lookup;
                end
                cache_pkg::st_lookup: begin
                    if (lookup_hit) begin
                        state <= req_we ? cache_pkg::st_store : cache_pkg::st_done;
                    end else begin
                        // dirty implies valid
                        mem_req <= 1'b1;
                        mem_we  <= victim_dirty;
                        state   <= victim_dirty ? cache_pkg::st_writeback
                                                : cache_pkg::st_refill;
                    end
                end
                cache_pkg::st_writeback: begin
                    // drop req on ack and refill once ack is gone
                    if (mem_req && mem_ack) begin
                        mem_req <= 1'b0;
                    end else if (!mem_req && !mem_ack) begin
                        mem_req <= 1'b1;
                        mem_we  <= 1'b0;
                        state   <= cache_pkg::st_refill;
                    end
                end
                cache_pkg::st_refill: begin
                    if (mem_req && mem_ack)
                        mem_req <= 1'b0;
                    else if (!mem_req && !mem_ack)
                        state <= cache_pkg::st_lookup;
                end
                cache_pkg::st_store: begin
                    // word lands on this edge together with ack
                    cpu_ack <= 1'b1;
                    state   <= cache_pkg::st_done;
                end
                cache_pkg::st_done: begin
                    if (!cpu_ack) begin
                        cpu_ack <= 1'b1;
                    end else if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= cache_pkg::st_idle;
                    end
                end
                default: state <= cache_pkg::st_idle;
            endcase
        end
    end

    // request, read data and memory payload
    always_ff @(posedge clk) begin
        if (state == cache_pkg::st_idle && cpu_req) begin
            req_addr  <= cpu_addr;
            req_we    <= cpu_we;
            req_wdata <= cpu_wdata;
        end
        if (state == cache_pkg::st_lookup) begin
            if (lookup_hit) begin
                // writes echo the stored word
                cpu_rdata <= req_we ? req_wdata : lookup_data;
            end else begin
                way_q     <= repl_way;
                mem_wdata <= victim_line;
                mem_addr  <= victim_dirty ? wb_addr : fill_addr;
            end
        end
        if (state == cache_pkg::st_writeback && !mem_req && !mem_ack) begin
            mem_addr <= fill_addr;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cache_pkg.sv ====
`default_nettype none

// ========================================
// shared types for the data cache
// ========================================
package cache_pkg;

    // bits in one data word
    localparam int WORD_BITS = 32;
    // byte offset below the word select
    localparam int BYTE_BITS = 2;

    // one data word
    typedef logic [WORD_BITS-1:0] word_t;

    // processor byte address
    typedef logic [31:0] addr_t;

    // controller states
    // store only entered after a hit
    // done holds ack until req falls
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_writeback,
        st_refill,
        st_store,
        st_done
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/cache_replace.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_replace #(
    parameter int WAYS = 2,
    parameter int SETS = 4,
    localparam int WAY_W = $clog2(WAYS),
    localparam int IDX_W = $clog2(SETS)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [IDX_W-1:0] index,
    input  logic             advance,
    output logic [WAY_W-1:0] victim_way
);

    // one fill pointer per set
    logic [WAY_W-1:0] ptr [SETS];

    assign victim_way = ptr[index];

    // only refills move the pointer so the order is fifo
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                ptr[s] <= '0;
            end
        end else if (advance) begin
            // wrap at WAYS rather than at the vector width
            if (ptr[index] == WAY_W'(WAYS - 1))
                ptr[index] <= '0;
            else
                ptr[index] <= ptr[index] + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_top #(
    parameter int WAYS           = 2,
    parameter int SETS           = 4,
    parameter int WORDS_PER_LINE = 4,
    localparam int WAY_W  = $clog2(WAYS),
    localparam int IDX_W  = $clog2(SETS),
    localparam int TAG_W  = 32 - IDX_W - $clog2(WORDS_PER_LINE) - cache_pkg::BYTE_BITS,
    localparam int LINE_W = WORDS_PER_LINE * cache_pkg::WORD_BITS
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    // processor port
    input  logic              cpu_req,
    input  logic              cpu_we,
    input  cache_pkg::addr_t  cpu_addr,
    input  cache_pkg::word_t  cpu_wdata,
    output logic              cpu_ack,
    output cache_pkg::word_t  cpu_rdata,
    // line wide memory port
    output logic              mem_req,
    output logic              mem_we,
    output cache_pkg::addr_t  mem_addr,
    output logic [LINE_W-1:0] mem_wdata,
    input  logic              mem_ack,
    input  logic [LINE_W-1:0] mem_rdata
);

    // ========================================
    // controller to core
    // ========================================
    cache_pkg::addr_t  lookup_addr;
    logic              lookup_hit;
    logic [WAY_W-1:0]  lookup_way;
    cache_pkg::word_t  lookup_data;
    logic              store_en;
    logic [WAY_W-1:0]  store_way;
    cache_pkg::word_t  store_data;
    logic              refill_en;
    cache_pkg::addr_t  refill_addr;
    logic [WAY_W-1:0]  refill_way;
    logic [LINE_W-1:0] refill_line;
    cache_pkg::addr_t  victim_addr;
    logic [WAY_W-1:0]  victim_way;
    logic [TAG_W-1:0]  victim_tag;
    logic              victim_dirty;
    logic [LINE_W-1:0] victim_line;
    // controller to replacement
    logic [IDX_W-1:0]  index;
    logic              advance;
    logic [WAY_W-1:0]  repl_way;

    // mem_we high only during write-back
    cache_ctrl #(.WAYS(WAYS), .SETS(SETS), .WORDS_PER_LINE(WORDS_PER_LINE)) u_ctrl (
        .clk(clk), .rst(rst),
        .cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
        .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .lookup_addr(lookup_addr), .store_en(store_en), .store_way(store_way),
        .store_data(store_data), .refill_en(refill_en), .refill_addr(refill_addr),
        .refill_way(refill_way), .refill_line(refill_line),
        .victim_addr(victim_addr), .victim_way(victim_way),
        .lookup_hit(lookup_hit), .lookup_way(lookup_way), .lookup_data(lookup_data),
        .victim_tag(victim_tag), .victim_dirty(victim_dirty), .victim_line(victim_line),
        .index(index), .advance(advance), .repl_way(repl_way)
    );

    cache_core #(.WAYS(WAYS), .SETS(SETS), .WORDS_PER_LINE(WORDS_PER_LINE)) u_core (
        .clk(clk), .rst(rst), .flush(flush),
        .lookup_addr(lookup_addr), .lookup_hit(lookup_hit), .lookup_way(lookup_way),
        .lookup_data(lookup_data),
        .store_en(store_en), .store_way(store_way), .store_data(store_data),
        .refill_en(refill_en), .refill_addr(refill_addr), .refill_way(refill_way),
        .refill_line(refill_line),
        .victim_addr(victim_addr), .victim_way(victim_way), .victim_tag(victim_tag),
        .victim_dirty(victim_dirty), .victim_line(victim_line)
    );

    // fifo victim choice per set
    cache_replace #(.WAYS(WAYS), .SETS(SETS)) u_replace (
        .clk(clk), .rst(rst),
        .index(index), .advance(advance), .victim_way(repl_way)
    );

endmodule

`default_nettype wire
